// ==== design/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

   // Data and address width of the whole machine
   localparam int DataWidth = 8;

   // General register count, addressed by two bits
   localparam int RegCount = 4;

   // Program counter after reset
   localparam logic [DataWidth-1:0] ResetPc = 8'h00;

   // Upper six bits of the opcode byte
   // Low two bits of the opcode byte select rd
   typedef enum logic [5:0] {
      NOP  = 6'd0,
      ADD  = 6'd1,
      ADC  = 6'd2,
      SUB  = 6'd3,
      AND  = 6'd4,
      OR   = 6'd5,
      XOR  = 6'd6,
      ADDI = 6'd7,
      ADCI = 6'd8,
      LDI  = 6'd9,
      ST   = 6'd10,
      JMP  = 6'd11,
      JZ   = 6'd12
   } opcodeT;

   // ALU operations
   typedef enum logic [2:0] {
      FnAdd  = 3'd0,
      FnAdc  = 3'd1,
      FnSub  = 3'd2,
      FnAnd  = 3'd3,
      FnOr   = 3'd4,
      FnXor  = 3'd5,
      FnPass = 3'd6
   } aluFunctionT;

   // Next PC source
   typedef enum logic {
      PcIncrement = 1'b0,
      PcOperand   = 1'b1
   } pcSelectT;

   // Register write-back source
   typedef enum logic {
      WdAlu     = 1'b0,
      WdOperand = 1'b1
   } wdSelectT;

   // Control steps, StoreData only follows ST
   typedef enum logic [2:0] {
      FetchAddr  = 3'd0,
      FetchGet   = 3'd1,
      DecodeAddr = 3'd2,
      DecodeGet  = 3'd3,
      Execute    = 3'd4,
      StoreData  = 3'd5
   } cpuStateT;

endpackage

`default_nettype wire

// ==== design/ctrlBus.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlBus;

   // ALU function for the execute step
   cpuPkg::aluFunctionT AluOp;
   // Second ALU operand, 0 picks rs, 1 picks the operand byte
   logic                Op2Sel;
   // Register file write
   logic                RegWe;
   // PC update and its source
   logic                PcEn;
   cpuPkg::pcSelectT    PcSel;
   // Instruction and operand byte capture
   logic                IrWe;
   logic                OprWe;
   // Carry and zero update
   logic                FlagWe;
   // Write-back source
   cpuPkg::wdSelectT    WdSel;
   // Bus address, 0 for the PC, 1 for the operand byte
   logic                AddrSel;

   modport control (
      output AluOp, Op2Sel, RegWe, PcEn, PcSel, IrWe, OprWe, FlagWe, WdSel, AddrSel
   );

   modport datapath (
      input AluOp, Op2Sel, RegWe, PcEn, PcSel, IrWe, OprWe, FlagWe, WdSel, AddrSel
   );

endinterface

`default_nettype wire

// ==== design/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
   input  cpuPkg::aluFunctionT AluOp,
   input  logic [7:0]          A,
   input  logic [7:0]          B,
   input  logic                CarryIn,
   output logic [7:0]          Result,
   output logic                CarryOut,
   output logic                ZeroOut
);

   // One bit wider to catch the carry
   logic [cpuPkg::DataWidth:0] sum;

   always_comb begin
      sum      = '0;
      Result   = B;
      CarryOut = 1'b0;

      case (AluOp)
         cpuPkg::FnAdd: begin
            sum      = {1'b0, A} + {1'b0, B};
            Result   = sum[7:0];
            CarryOut = sum[8];
         end
         cpuPkg::FnAdc: begin
            // Carry flag feeds the low bit
            sum      = {1'b0, A} + {1'b0, B} + {8'h00, CarryIn};
            Result   = sum[7:0];
            CarryOut = sum[8];
         end
         cpuPkg::FnSub: begin
            // A + ~B + 1, carry out high when no borrow
            sum      = {1'b0, A} + {1'b0, ~B} + 9'd1;
            Result   = sum[7:0];
            CarryOut = sum[8];
         end
         // Logic ops leave carry clear
         cpuPkg::FnAnd: begin
            Result = A & B;
         end
         cpuPkg::FnOr: begin
            Result = A | B;
         end
         cpuPkg::FnXor: begin
            Result = A ^ B;
         end
         // Pass B through
         default: begin
            Result = B;
         end
      endcase
   end

   // Zero flag source
   assign ZeroOut = (Result == 8'h00);

endmodule

`default_nettype wire

// ==== design/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
   input  logic           Clock,
   input  logic           nReset,
   input  logic [7:0]     OpCode,
   input  logic           Zero,
   ctrlBus.control        ctrl,
   output logic           Ale,
   output logic           Enb,
   output logic           Rw
);

   cpuPkg::cpuStateT state;
   cpuPkg::cpuStateT nextState;
   cpuPkg::opcodeT   opcode;

   // Instruction class from the top six bits
   assign opcode = cpuPkg::opcodeT'(OpCode[7:2]);

   // Reset parks in Execute with the IR holding NOP
   // so the first edge after release enters FetchAddr
   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         state <= cpuPkg::Execute;
      end else begin
         state <= nextState;
      end
   end

   // Fixed step order, ST adds one data cycle
   always_comb begin
      case (state)
         cpuPkg::FetchAddr:  nextState = cpuPkg::FetchGet;
         cpuPkg::FetchGet:   nextState = cpuPkg::DecodeAddr;
         cpuPkg::DecodeAddr: nextState = cpuPkg::DecodeGet;
         cpuPkg::DecodeGet:  nextState = cpuPkg::Execute;
         cpuPkg::Execute: begin
            if (opcode == cpuPkg::ST) begin
               nextState = cpuPkg::StoreData;
            end else begin
               nextState = cpuPkg::FetchAddr;
            end
         end
         default:            nextState = cpuPkg::FetchAddr;
      endcase
   end

   // Strobes and datapath controls
   always_comb begin
      // Idle values, reads by default
      Ale          = 1'b0;
      Enb          = 1'b0;
      Rw           = 1'b1;
      ctrl.AluOp   = cpuPkg::FnPass;
      ctrl.Op2Sel  = 1'b0;
      ctrl.RegWe   = 1'b0;
      ctrl.PcEn    = 1'b0;
      ctrl.PcSel   = cpuPkg::PcIncrement;
      ctrl.IrWe    = 1'b0;
      ctrl.OprWe   = 1'b0;
      ctrl.FlagWe  = 1'b0;
      ctrl.WdSel   = cpuPkg::WdAlu;
      ctrl.AddrSel = 1'b0;

      case (state)
         // Opcode address from PC
         cpuPkg::FetchAddr: begin
            Ale = 1'b1;
         end
         // Opcode byte into IR, step PC
         cpuPkg::FetchGet: begin
            Enb       = 1'b1;
            ctrl.IrWe = 1'b1;
            ctrl.PcEn = 1'b1;
         end
         // Operand address from PC
         cpuPkg::DecodeAddr: begin
            Ale = 1'b1;
         end
         // Operand byte in, step PC again
         cpuPkg::DecodeGet: begin
            Enb        = 1'b1;
            ctrl.OprWe = 1'b1;
            ctrl.PcEn  = 1'b1;
         end
         cpuPkg::Execute: begin
            case (opcode)
               cpuPkg::ADD, cpuPkg::ADC, cpuPkg::SUB,
               cpuPkg::AND, cpuPkg::OR, cpuPkg::XOR: begin
                  // Register to register ALU op
                  ctrl.RegWe  = 1'b1;
                  ctrl.FlagWe = 1'b1;
                  case (opcode)
                     cpuPkg::ADD: ctrl.AluOp = cpuPkg::FnAdd;
                     cpuPkg::ADC: ctrl.AluOp = cpuPkg::FnAdc;
                     cpuPkg::SUB: ctrl.AluOp = cpuPkg::FnSub;
                     cpuPkg::AND: ctrl.AluOp = cpuPkg::FnAnd;
                     cpuPkg::OR:  ctrl.AluOp = cpuPkg::FnOr;
                     default:     ctrl.AluOp = cpuPkg::FnXor;
                  endcase
               end
               cpuPkg::ADDI, cpuPkg::ADCI: begin
                  // Immediate goes in as operand B
                  ctrl.Op2Sel = 1'b1;
                  ctrl.RegWe  = 1'b1;
                  ctrl.FlagWe = 1'b1;
                  if (opcode == cpuPkg::ADCI) begin
                     ctrl.AluOp = cpuPkg::FnAdc;
                  end else begin
                     ctrl.AluOp = cpuPkg::FnAdd;
                  end
               end
               cpuPkg::LDI: begin
                  // Operand byte straight into rd, flags kept
                  ctrl.RegWe = 1'b1;
                  ctrl.WdSel = cpuPkg::WdOperand;
               end
               cpuPkg::ST: begin
                  // Store address phase
                  Ale          = 1'b1;
                  ctrl.AddrSel = 1'b1;
               end
               cpuPkg::JMP: begin
                  ctrl.PcEn  = 1'b1;
                  ctrl.PcSel = cpuPkg::PcOperand;
               end
               cpuPkg::JZ: begin
                  // Taken only on a zero result
                  ctrl.PcEn  = Zero;
                  ctrl.PcSel = cpuPkg::PcOperand;
               end
               default: begin
                  // NOP and unused codes do nothing
               end
            endcase
         end
         // Write data phase of ST
         cpuPkg::StoreData: begin
            Enb          = 1'b1;
            Rw           = 1'b0;
            ctrl.AddrSel = 1'b1;
         end
         default: begin
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== design/dataPath.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataPath (
   input  logic           Clock,
   input  logic           nReset,
   ctrlBus.datapath       ctrl,
   input  logic [7:0]     ReadData,
   output logic [7:0]     OpCode,
   output logic           Zero,
   output logic [7:0]     Address,
   output logic [7:0]     WriteData
);

   logic [cpuPkg::DataWidth-1:0] pc;
   logic [cpuPkg::DataWidth-1:0] ir;
   logic [cpuPkg::DataWidth-1:0] opr;
   logic [cpuPkg::DataWidth-1:0] regFile [cpuPkg::RegCount];
   logic                         carryFlag;
   logic                         zeroFlag;

   logic [1:0]                   rd;
   logic [1:0]                   rs;
   logic [cpuPkg::DataWidth-1:0] aluA;
   logic [cpuPkg::DataWidth-1:0] aluB;
   logic [cpuPkg::DataWidth-1:0] aluResult;
   logic                         aluCarry;
   logic                         aluZero;
   logic [cpuPkg::DataWidth-1:0] writeBack;

   // Destination in the opcode, source in the operand
   assign rd = ir[1:0];
   assign rs = opr[1:0];

   // Operand muxes
   assign aluA = regFile[rd];
   assign aluB = ctrl.Op2Sel ? opr : regFile[rs];

   aluUnit i_aluUnit (
      .AluOp    (ctrl.AluOp),
      .A        (aluA),
      .B        (aluB),
      .CarryIn  (carryFlag),
      .Result   (aluResult),
      .CarryOut (aluCarry),
      .ZeroOut  (aluZero)
   );

   // Write-back source
   assign writeBack = (ctrl.WdSel == cpuPkg::WdOperand) ? opr : aluResult;

   // PC and IR
   // IR clears to NOP so the parked reset step is harmless
   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         pc <= cpuPkg::ResetPc;
         ir <= {cpuPkg::NOP, 2'b00};
      end else begin
         if (ctrl.PcEn) begin
            if (ctrl.PcSel == cpuPkg::PcOperand) begin
               pc <= opr;
            end else begin
               pc <= pc + 8'd1;
            end
         end
         if (ctrl.IrWe) begin
            ir <= ReadData;
         end
      end
   end

   // Carry and zero, updated by ALU ops only
   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         carryFlag <= 1'b0;
         zeroFlag  <= 1'b0;
      end else if (ctrl.FlagWe) begin
         carryFlag <= aluCarry;
         zeroFlag  <= aluZero;
      end
   end

   // Operand byte and register file
   always_ff @(posedge Clock) begin
      if (ctrl.OprWe) begin
         opr <= ReadData;
      end
      if (ctrl.RegWe) begin
         regFile[rd] <= writeBack;
      end
   end

   // Bus address: PC for fetches, operand for ST
   assign Address   = ctrl.AddrSel ? opr : pc;
   // Store data always comes from rd
   assign WriteData = regFile[rd];

   assign OpCode = ir;
   assign Zero   = zeroFlag;

endmodule

`default_nettype wire

// ==== design/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
   input  logic       Clock,
   input  logic       nReset,
   input  logic [7:0] ReadData,
   output logic [7:0] Address,
   output logic [7:0] WriteData,
   output logic       Ale,
   output logic       Enb,
   output logic       Rw
);

   // Instruction byte and zero flag back to control
   logic [7:0] opCode;
   logic       zero;

   // Control to datapath signals
   ctrlBus ctrl ();

   // Sequencer and bus strobes
   controlUnit i_controlUnit (
      .Clock  (Clock),
      .nReset (nReset),
      .OpCode (opCode),
      .Zero   (zero),
      .ctrl   (ctrl.control),
      .Ale    (Ale),
      .Enb    (Enb),
      .Rw     (Rw)
   );

   // Registers, ALU and bus address and data
   dataPath i_dataPath (
      .Clock     (Clock),
      .nReset    (nReset),
      .ctrl      (ctrl.datapath),
      .ReadData  (ReadData),
      .OpCode    (opCode),
      .Zero      (zero),
      .Address   (Address),
      .WriteData (WriteData)
   );

endmodule

`default_nettype wire

// ==== sim/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock (
   output logic Clock
);

   // Starts low, first rising edge at 4 ns
   initial begin
      Clock = 1'b0;
   end

   // 8 ns period
   always begin
      #4 Clock = ~Clock;
   end

endmodule

`default_nettype wire

// ==== sim/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

   logic       Clock;
   logic       nReset   = 1'b0;
   logic [7:0] ReadData = 8'h00;
   logic [7:0] Address;
   logic [7:0] WriteData;
   logic       Ale;
   logic       Enb;
   logic       Rw;

   // Memory and the address captured at Ale
   logic [7:0] memory [256];
   logic [7:0] addrLatch = 8'h00;

   // Program image bookkeeping
   logic [7:0] progLen;
   logic [7:0] haltAddr;
   logic [7:0] storeNext;
   int         instrCount;
   int         storesEmitted;
   int         cycleLimit;

   // Reference model
   logic [7:0] modelRegs [4];
   logic       modelCarry = 1'b0;
   logic       modelZero  = 1'b0;
   logic [7:0] expectedPc = 8'h00;
   logic [7:0] fetchPc    = 8'h00;
   logic       isStore    = 1'b0;
   logic [7:0] storeAddr  = 8'h00;
   logic [7:0] storeData  = 8'h00;

   // Bus monitor
   int         phase       = 0;
   int         resetCycles = 0;
   int         cycleCount  = 0;
   int         writesSeen  = 0;
   logic       haltSeen    = 1'b0;

   tbClock i_clock (
      .Clock (Clock)
   );

   cpuTop i_dut (
      .Clock     (Clock),
      .nReset    (nReset),
      .ReadData  (ReadData),
      .Address   (Address),
      .WriteData (WriteData),
      .Ale       (Ale),
      .Enb       (Enb),
      .Rw        (Rw)
   );

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic reportMismatch(input string what);
      abortRun($sformatf("MISMATCH at %0t: %s", $time, what));
   endtask

   // Opcode byte then operand byte
   task automatic emit(input cpuPkg::opcodeT code, input logic [1:0] rd,
                       input logic [7:0] operand);
      memory[progLen]         = {code, rd};
      memory[progLen + 8'd1]  = operand;
      progLen                 = progLen + 8'd2;
      instrCount++;
      if (code == cpuPkg::ST) begin
         storesEmitted++;
      end
   endtask

   // Dump r0 to r3 into the next four result bytes
   task automatic emitStoreAll();
      for (int r = 0; r < 4; r++) begin
         emit(cpuPkg::ST, r[1:0], storeNext);
         storeNext = storeNext + 8'd1;
      end
   endtask

   task automatic emitRandomBlock(input int count);
      logic [2:0] pick;
      for (int n = 0; n < count; n++) begin
         pick = 3'($urandom_range(7));
         // ADD through ADCI are codes 1 to 8
         emit(cpuPkg::opcodeT'(6'(pick) + 6'd1), 2'($urandom), 8'($urandom));
      end
      emitStoreAll();
   endtask

   // Instruction rules applied when the opcode byte is fetched
   task automatic applyInstruction(input logic [7:0] pcValue);
      logic [7:0]     opByte;
      logic [7:0]     operand;
      logic [1:0]     rd;
      logic [7:0]     a;
      logic [7:0]     b;
      logic [8:0]     wide;
      logic           isAlu;
      cpuPkg::opcodeT opName;

      opByte  = memory[pcValue];
      operand = memory[pcValue + 8'd1];
      opName  = cpuPkg::opcodeT'(opByte[7:2]);
      rd      = opByte[1:0];
      a       = modelRegs[rd];
      // Register forms take rs from operand bits 1:0
      if (opName == cpuPkg::ADDI || opName == cpuPkg::ADCI) begin
         b = operand;
      end else begin
         b = modelRegs[operand[1:0]];
      end
      wide       = 9'h000;
      isAlu      = 1'b1;
      isStore    = 1'b0;
      expectedPc = pcValue + 8'd2;

      case (opName)
         cpuPkg::ADD, cpuPkg::ADDI: wide = {1'b0, a} + {1'b0, b};
         cpuPkg::ADC, cpuPkg::ADCI: wide = {1'b0, a} + {1'b0, b} + {8'h00, modelCarry};
         // Carry high when nothing was borrowed
         cpuPkg::SUB:               wide = {a >= b, a - b};
         cpuPkg::AND:               wide = {1'b0, a & b};
         cpuPkg::OR:                wide = {1'b0, a | b};
         cpuPkg::XOR:               wide = {1'b0, a ^ b};
         default:                   isAlu = 1'b0;
      endcase

      if (isAlu) begin
         modelRegs[rd] = wide[7:0];
         modelCarry    = wide[8];
         modelZero     = (wide[7:0] == 8'h00);
      end

      case (opName)
         cpuPkg::LDI: modelRegs[rd] = operand;
         cpuPkg::ST: begin
            isStore   = 1'b1;
            storeAddr = operand;
            storeData = modelRegs[rd];
         end
         cpuPkg::JMP: expectedPc = operand;
         cpuPkg::JZ: begin
            if (modelZero) begin
               expectedPc = operand;
            end
         end
         default: begin
         end
      endcase
   endtask

   // One bus cycle against the expected step of the instruction
   task automatic checkBusCycle();
      case (phase)
         0: begin
            assert (Ale && !Enb && Rw)
               else reportMismatch("no opcode address strobe at instruction start");
            assert (Address == expectedPc)
               else reportMismatch($sformatf("fetch address %02h, expected %02h",
                                             Address, expectedPc));
            fetchPc = expectedPc;
            if (fetchPc == haltAddr) begin
               haltSeen = 1'b1;
            end else begin
               applyInstruction(fetchPc);
            end
         end
         1, 3: begin
            assert (!Ale && Enb && Rw)
               else reportMismatch("read data strobe missing");
         end
         2: begin
            assert (Ale && !Enb && Rw)
               else reportMismatch("no operand address strobe");
            assert (Address == fetchPc + 8'd1)
               else reportMismatch($sformatf("operand address %02h, expected %02h",
                                             Address, fetchPc + 8'd1));
         end
         4: begin
            if (isStore) begin
               assert (Ale && !Enb && Rw)
                  else reportMismatch("no store address strobe");
               assert (Address == storeAddr)
                  else reportMismatch($sformatf("store address %02h, expected %02h",
                                                Address, storeAddr));
            end else begin
               // Execute step is quiet on the bus
               assert (!Ale && !Enb && Rw)
                  else reportMismatch("bus active in execute step");
            end
         end
         default: begin
            assert (!Ale && Enb && !Rw)
               else reportMismatch("write strobe missing after store address");
            assert (WriteData == storeData)
               else reportMismatch($sformatf("store data %02h at %02h, expected %02h",
                                             WriteData, storeAddr, storeData));
            writesSeen++;
         end
      endcase

      if (Ale) begin
         addrLatch = Address;
      end
      if (Enb && !Rw) begin
         memory[addrLatch] = WriteData;
      end

      // Five steps per instruction and six for ST
      if ((phase == 4 && !isStore) || phase == 5) begin
         phase = 0;
      end else begin
         phase++;
      end
   endtask

   task automatic finishRun();
      if (writesSeen == storesEmitted) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         reportMismatch($sformatf("halt reached after %0d stores, expected %0d",
                                  writesSeen, storesEmitted));
      end
   endtask

   initial begin
      // Background pattern over the whole address
      for (int i = 0; i < 256; i++) begin
         memory[i[7:0]] = i[7:0] ^ 8'h5a;
      end
      void'($urandom(32'hb3fb));
      progLen       = 8'h00;
      storeNext     = 8'hc0;
      instrCount    = 0;
      storesEmitted = 0;

      // Loads, register ALU ops, NOP
      emit(cpuPkg::LDI, 2'd0, 8'h5a);
      emit(cpuPkg::LDI, 2'd1, 8'h3c);
      emit(cpuPkg::LDI, 2'd2, 8'hf0);
      emit(cpuPkg::LDI, 2'd3, 8'h0f);
      emit(cpuPkg::ADD, 2'd0, 8'h01);
      emit(cpuPkg::SUB, 2'd2, 8'h03);
      emit(cpuPkg::AND, 2'd1, 8'h03);
      emit(cpuPkg::OR, 2'd3, 8'h02);
      emit(cpuPkg::XOR, 2'd0, 8'h02);
      emit(cpuPkg::ADDI, 2'd1, 8'h11);
      emit(cpuPkg::NOP, 2'd0, 8'ha5);
      emitStoreAll();

      // Carry from overflowing adds into ADCI and ADC
      emit(cpuPkg::LDI, 2'd0, 8'hf0);
      emit(cpuPkg::LDI, 2'd1, 8'h01);
      emit(cpuPkg::LDI, 2'd3, 8'h00);
      emit(cpuPkg::ADDI, 2'd0, 8'h20);
      emit(cpuPkg::ADCI, 2'd3, 8'h05);
      emit(cpuPkg::LDI, 2'd0, 8'hff);
      emit(cpuPkg::ADD, 2'd0, 8'h01);
      // ADC overflows too and leaves carry set for the AND
      emit(cpuPkg::LDI, 2'd2, 8'hff);
      emit(cpuPkg::ADC, 2'd2, 8'h01);
      // Logic op clears carry before ADC
      emit(cpuPkg::AND, 2'd1, 8'h01);
      emit(cpuPkg::ADC, 2'd1, 8'h01);
      emitStoreAll();

      // Each of JZ taken, JZ not taken and JMP sits over one LDI
      emit(cpuPkg::SUB, 2'd0, 8'h00);
      emit(cpuPkg::JZ, 2'd0, progLen + 8'd4);
      emit(cpuPkg::LDI, 2'd0, 8'hee);
      emit(cpuPkg::LDI, 2'd1, 8'h01);
      emit(cpuPkg::OR, 2'd1, 8'h01);
      emit(cpuPkg::JZ, 2'd0, progLen + 8'd4);
      emit(cpuPkg::LDI, 2'd2, 8'h77);
      emit(cpuPkg::JMP, 2'd0, progLen + 8'd4);
      emit(cpuPkg::LDI, 2'd3, 8'hdd);
      emitStoreAll();

      emitRandomBlock(10);
      emitRandomBlock(10);

      // Jump to itself marks the end of the program
      haltAddr = progLen;
      emit(cpuPkg::JMP, 2'd0, progLen);
      cycleLimit = instrCount * 6 + 100;
   end

   // Inputs change and outputs are sampled mid cycle
   always @(negedge Clock) begin
      if (!nReset) begin
         assert (!Ale && !Enb)
            else reportMismatch("bus strobe active during reset");
         resetCycles++;
         if (resetCycles == 16) begin
            nReset = 1'b1;
         end
      end else begin
         cycleCount++;
         if (cycleCount > cycleLimit) begin
            abortRun($sformatf("Timeout: halt address never fetched within %0d cycles",
                               cycleLimit));
         end
         checkBusCycle();
      end
      // Reads answer from the latched address
      ReadData = memory[addrLatch];
      if (haltSeen) begin
         finishRun();
      end
   end

endmodule

`default_nettype wire

// ==== flist.f ====
design/cpuPkg.sv
design/ctrlBus.sv
design/aluUnit.sv
design/controlUnit.sv
design/dataPath.sv
design/cpuTop.sv
sim/tbClock.sv
sim/cpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module cpuTb \
   --Mdir obj_dir \
   -o cpuTbSim \
   -f flist.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/cpuTbSim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi

exit 0
